// File: design/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int word_size = 16;

    typedef logic [word_size-1:0] word_t;
    typedef logic [1:0] reg_idx_t;

    typedef enum logic [3:0] {
        op_bne   = 4'd0,
        op_beq   = 4'd1,
        op_adi   = 4'd4,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_jmp   = 4'd9,
        op_rtype = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } func_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        func_t    func;
    } r_fmt_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [7:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [11:0] target;
    } j_fmt_t;

    // one fetched word in three field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2,
        alu_or  = 2'd3
    } alu_op_t;

endpackage

// File: design/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        alu_op_t alu_op;
        logic    is_wwd;
        logic    is_halt;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;   // destination already picked per format
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
        word_t    wwd_val;
    } ex_mem_t;

    // writeback bus seen by decode and execute
    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    value;
    } wb_bus_t;

endpackage

// File: design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  target,
    output word_t  instr_addr,
    input  word_t  instr_data,
    input  logic   fetch_en,
    output if_id_t if_id
);

    word_t pc;
    logic  advance;

    assign instr_addr = pc;

    // stall wins over redirect so the branch is looked at again next cycle
    assign advance = fetch_en && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= reset_pc;
            if_id <= '0;
        end else if (advance) begin
            if (redirect) begin
                pc          <= target;
                if_id.valid <= 1'b0;  // squash the wrong-path fetch
            end else begin
                pc          <= pc + word_t'(1);
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= instr_data;
            end
        end
    end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  if_id_t  if_id,
    input  ex_mem_t ex_fwd,
    input  wb_bus_t wb,
    output logic    stall,
    output logic    redirect,
    output word_t   target,
    input  logic    halted,
    output id_ex_t  id_ex
);

    word_t    regs [4];
    instr_u   ins;
    ctrl_t    ctrl;
    reg_idx_t dst;
    logic     uses_rs, uses_rt, is_branch, is_jmp;
    word_t    rs_raw, rt_raw, br_a, br_b, imm;
    logic     load_use, br_wait, halt_down, hazard, bubble, taken;

    function automatic logic in_ex(reg_idx_t r);
        return id_ex.valid && id_ex.ctrl.reg_write && id_ex.rd == r;
    endfunction

    function automatic logic in_mem(reg_idx_t r);
        return ex_fwd.valid && ex_fwd.ctrl.reg_write && ex_fwd.rd == r;
    endfunction

    assign ins = if_id.instr;
    assign imm = {{8{ins.i.imm[7]}}, ins.i.imm};

    always_comb begin
        ctrl      = '0;
        dst       = ins.r.rd;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        is_jmp    = 1'b0;
        case (ins.r.opcode)
            op_rtype: begin
                uses_rs = 1'b1;
                case (ins.r.func)
                    fn_add, fn_sub, fn_and, fn_orr: begin
                        uses_rt        = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_op_t'(ins.r.func[1:0]);
                    end
                    fn_wwd:  ctrl.is_wwd = 1'b1;
                    fn_hlt:  ctrl.is_halt = 1'b1;
                    default: ;
                endcase
            end
            op_adi, op_lwd: begin
                uses_rs          = 1'b1;
                dst              = ins.i.rt;
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = (ins.i.opcode == op_lwd);
            end
            op_swd: begin
                uses_rs          = 1'b1;
                uses_rt          = 1'b1;  // store data
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            op_bne, op_beq: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                is_branch = 1'b1;
            end
            op_jmp:  is_jmp = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb.reg_write)
            regs[wb.rd] <= wb.value;
    end

    // same-cycle writeback bypass
    assign rs_raw = (wb.reg_write && wb.rd == ins.r.rs) ? wb.value : regs[ins.r.rs];
    assign rt_raw = (wb.reg_write && wb.rd == ins.r.rt) ? wb.value : regs[ins.r.rt];

    assign br_a = in_mem(ins.r.rs) ? ex_fwd.alu_result : rs_raw;
    assign br_b = in_mem(ins.r.rt) ? ex_fwd.alu_result : rt_raw;

    assign load_use = id_ex.valid && id_ex.ctrl.mem_read &&
                      ((uses_rs && id_ex.rd == ins.r.rs) || (uses_rt && id_ex.rd == ins.r.rt));
    assign br_wait  = is_branch &&
                      (in_ex(ins.r.rs) || in_ex(ins.r.rt) ||
                       (ex_fwd.ctrl.mem_read && (in_mem(ins.r.rs) || in_mem(ins.r.rt))));
    assign halt_down = (id_ex.valid && id_ex.ctrl.is_halt) ||
                       (ex_fwd.valid && ex_fwd.ctrl.is_halt) || halted;

    assign hazard = if_id.valid && (load_use || br_wait);
    assign bubble = hazard || halt_down;
    // a HLT in ID still issues once while fetch stops behind it
    assign stall  = bubble || (if_id.valid && ctrl.is_halt);

    assign taken    = is_jmp || (is_branch && ((ins.i.opcode == op_beq) == (br_a == br_b)));
    assign redirect = if_id.valid && taken && !stall;
    assign target   = is_jmp ? {if_id.pc[15:12], ins.j.target} : if_id.pc + word_t'(1) + imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex.valid  <= if_id.valid && !bubble;
            id_ex.ctrl   <= (if_id.valid && !bubble) ? ctrl : '0;
            id_ex.rs     <= ins.r.rs;
            id_ex.rt     <= ins.r.rt;
            id_ex.rd     <= dst;
            id_ex.rs_val <= rs_raw;
            id_ex.rt_val <= rt_raw;
            id_ex.imm    <= imm;
        end
    end

    // the fetch behind a taken branch never reaches ID
    redirect_flushes: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !if_id.valid);

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem,
    input  wb_bus_t wb
);

    word_t op_a, op_b, rt_fwd, result;

    // EX/MEM first, then writeback, then the value read in ID
    function automatic word_t pick(reg_idx_t r, word_t rf_val);
        if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd == r)
            return ex_mem.alu_result;
        else if (wb.reg_write && wb.rd == r)
            return wb.value;
        else
            return rf_val;
    endfunction

    assign op_a   = pick(id_ex.rs, id_ex.rs_val);
    assign rt_fwd = pick(id_ex.rt, id_ex.rt_val);
    assign op_b   = id_ex.ctrl.alu_src_imm ? id_ex.imm : rt_fwd;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            default: result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= result;  // also the memory address
            ex_mem.store_data <= rt_fwd;
            ex_mem.wwd_val    <= op_a;
        end
    end

endmodule

// File: design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    output logic    read_m2,
    output logic    write_m2,
    output word_t   address2,
    output word_t   write_data2,
    input  word_t   read_data2,
    output wb_bus_t wb,
    output word_t   output_port,
    output logic    output_valid,
    output word_t   num_inst,
    output logic    is_halted
);

    ex_mem_t mem_in, mem_wb_q;
    logic    halt_q;

    assign read_m2     = ex_mem.valid && ex_mem.ctrl.mem_read;
    assign write_m2    = ex_mem.valid && ex_mem.ctrl.mem_write;
    assign address2    = ex_mem.alu_result;
    assign write_data2 = ex_mem.store_data;

    always_comb begin
        mem_in = ex_mem;
        if (read_m2)
            mem_in.alu_result = read_data2;  // load data replaces the address
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_q <= '0;
            num_inst <= '0;
            halt_q   <= 1'b0;
        end else begin
            mem_wb_q <= mem_in;
            if (mem_wb_q.valid)
                num_inst <= num_inst + word_t'(1);
            if (mem_wb_q.valid && mem_wb_q.ctrl.is_halt)
                halt_q <= 1'b1;
        end
    end

    assign wb.reg_write = mem_wb_q.valid && mem_wb_q.ctrl.reg_write;
    assign wb.rd        = mem_wb_q.rd;
    assign wb.value     = mem_wb_q.alu_result;

    assign output_port  = mem_wb_q.wwd_val;
    assign output_valid = mem_wb_q.valid && mem_wb_q.ctrl.is_wwd;
    // high already in the HLT's own WB cycle
    assign is_halted    = halt_q || (mem_wb_q.valid && mem_wb_q.ctrl.is_halt);

    mem_strobes_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_m2 && write_m2));

    // nothing retires once halted
    halt_is_final: assert property (@(posedge clk) disable iff (!rst_n)
        halt_q |=> !output_valid && $stable(num_inst));

endmodule

// File: design/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    output logic  read_m1,
    output word_t address1,
    input  word_t data1,
    output logic  read_m2,
    output logic  write_m2,
    output word_t address2,
    output word_t write_data2,
    input  word_t read_data2,
    output word_t output_port,
    output logic  output_valid,
    output word_t num_inst,
    output logic  is_halted
);

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_bus_t wb;
    logic    stall, redirect;
    word_t   target;

    assign read_m1 = !is_halted;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .redirect   (redirect),
        .target     (target),
        .instr_addr (address1),
        .instr_data (data1),
        .fetch_en   (read_m1),
        .if_id      (if_id)
    );

    decode_stage i_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_id    (if_id),
        .ex_fwd   (ex_mem),
        .wb       (wb),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .halted   (is_halted),  // keeps fetch stalled for good
        .id_ex    (id_ex)
    );

    execute_stage i_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .wb     (wb)
    );

    mem_wb_stage i_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_mem       (ex_mem),
        .read_m2      (read_m2),
        .write_m2     (write_m2),
        .address2     (address2),
        .write_data2  (write_data2),
        .read_data2   (read_data2),
        .wb           (wb),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;  // released just after an edge
    end

endmodule

// File: verification/tb_memory.sv
`timescale 1ns/1ps

module tb_memory
    import cpu_isa_pkg::*;
(
    input  logic       clk,
    input  logic       load_en,
    input  logic [7:0] load_addr,
    input  word_t      load_instr,
    input  word_t      load_data,
    input  word_t      instr_addr,
    output word_t      instr_data,
    input  logic       read_m2,
    input  logic       write_m2,
    input  word_t      data_addr,
    input  word_t      write_data,
    output word_t      read_data
);

    word_t imem [256];
    word_t dmem [256];

    // both reads answer in the same cycle
    assign instr_data = imem[instr_addr[7:0]];
    assign read_data  = read_m2 ? dmem[data_addr[7:0]] : '0;  // data only on a read strobe

    always @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_instr;
            dmem[load_addr] <= load_data;
        end else if (write_m2) begin
            dmem[data_addr[7:0]] <= write_data;
        end
    end

endmodule

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
    import cpu_isa_pkg::*;
();

    localparam int n_rows    = 5;
    localparam int row_limit = 40;
    localparam int max_cycles = n_rows * row_limit + 3;

    typedef struct {
        string name;
        word_t prog [12];
        int    n_exp;
        word_t exp_val [4];
        word_t exp_addr [4];  // ffff for a fixed value or a data address for a load
        int    exp_count;
        logic  rand_fill;
        int    reset_after;   // cycles before a mid-program reset or 0
    } row_t;

    row_t  rows [n_rows];
    word_t got [$];
    int    errors, passed, cycles;

    logic  clk, gen_rst_n, run_rst_n, dut_rst_n;
    logic  load_en;
    logic [7:0] load_addr;
    word_t load_instr, load_data;
    logic  read_m1, read_m2, write_m2, output_valid, is_halted;
    word_t address1, data1, address2, write_data2, read_data2, output_port, num_inst;

    assign dut_rst_n = gen_rst_n && run_rst_n;

    tb_clock_gen #(.period_ns(4), .reset_cycles(3)) i_clk (.clk(clk), .rst_n(gen_rst_n));

    tb_memory i_mem (
        .clk        (clk),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_instr (load_instr),
        .load_data  (load_data),
        .instr_addr (address1),
        .instr_data (data1),
        .read_m2    (read_m2),
        .write_m2   (write_m2),
        .data_addr  (address2),
        .write_data (write_data2),
        .read_data  (read_data2)
    );

    cpu_core #(.reset_pc(16'h0000)) i_dut (
        .clk          (clk),
        .rst_n        (dut_rst_n),
        .read_m1      (read_m1),
        .address1     (address1),
        .data1        (data1),
        .read_m2      (read_m2),
        .write_m2     (write_m2),
        .address2     (address2),
        .write_data2  (write_data2),
        .read_data2   (read_data2),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, func_t fn);
        return {op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(logic [11:0] tgt);
        return {op_jmp, tgt};
    endfunction

    task automatic build_table();
        word_t hlt, clr;
        hlt = enc_r(2'd0, 2'd0, 2'd0, fn_hlt);
        clr = enc_r(2'd0, 2'd0, 2'd0, fn_sub);  // r0 = r0 - r0
        rows[0] = '{"forward chain", '{clr, enc_i(op_adi, 2'd0, 2'd1, 8'd5),
            enc_i(op_adi, 2'd1, 2'd2, 8'd3), enc_r(2'd1, 2'd2, 2'd3, fn_add),
            enc_r(2'd3, 2'd0, 2'd0, fn_wwd), enc_r(2'd3, 2'd2, 2'd1, fn_sub),
            enc_r(2'd3, 2'd1, 2'd2, fn_and), enc_i(op_adi, 2'd0, 2'd0, 8'hf0),
            enc_r(2'd0, 2'd2, 2'd3, fn_orr), enc_r(2'd3, 2'd0, 2'd0, fn_wwd),
            enc_r(2'd2, 2'd0, 2'd0, fn_wwd), hlt},
            3, '{16'd13, 16'hfff5, 16'd5, 16'd0}, '{16'hffff, 16'hffff, 16'hffff, 16'hffff},
            12, 1'b0, 0};
        rows[1] = '{"load store", '{clr, enc_i(op_lwd, 2'd0, 2'd1, 8'd5),
            enc_r(2'd1, 2'd0, 2'd0, fn_wwd), enc_i(op_adi, 2'd0, 2'd3, 8'd7),
            enc_i(op_swd, 2'd0, 2'd3, 8'd9), enc_i(op_lwd, 2'd0, 2'd2, 8'd9),
            enc_r(2'd2, 2'd0, 2'd0, fn_wwd), hlt, hlt, hlt, hlt, hlt},
            2, '{16'd0, 16'd7, 16'd0, 16'd0}, '{16'd5, 16'hffff, 16'hffff, 16'hffff},
            8, 1'b1, 0};
        // skipped WWDs would print 0
        rows[2] = '{"branches", '{clr, enc_i(op_adi, 2'd0, 2'd1, 8'd1),
            enc_i(op_beq, 2'd1, 2'd0, 8'd1), enc_i(op_bne, 2'd1, 2'd0, 8'd1),
            enc_r(2'd0, 2'd0, 2'd0, fn_wwd), enc_j(12'd7),
            enc_r(2'd0, 2'd0, 2'd0, fn_wwd), enc_i(op_adi, 2'd0, 2'd2, 8'd2),
            enc_i(op_beq, 2'd2, 2'd2, 8'd1), enc_r(2'd0, 2'd0, 2'd0, fn_wwd),
            enc_r(2'd2, 2'd0, 2'd0, fn_wwd), hlt},
            1, '{16'd2, 16'd0, 16'd0, 16'd0}, '{16'hffff, 16'hffff, 16'hffff, 16'hffff},
            9, 1'b0, 0};
        // not-taken BNE right behind its ADI
        rows[3] = '{"halt", '{clr, enc_i(op_adi, 2'd0, 2'd1, 8'd9),
            enc_i(op_bne, 2'd1, 2'd1, 8'd1), enc_r(2'd1, 2'd0, 2'd0, fn_wwd), hlt,
            enc_r(2'd1, 2'd0, 2'd0, fn_wwd), enc_i(op_adi, 2'd0, 2'd1, 8'd1),
            enc_r(2'd1, 2'd0, 2'd0, fn_wwd), hlt, hlt, hlt, hlt},
            1, '{16'd9, 16'd0, 16'd0, 16'd0}, '{16'hffff, 16'hffff, 16'hffff, 16'hffff},
            5, 1'b0, 0};
        rows[4] = rows[0];
        rows[4].name = "mid reset";
        rows[4].reset_after = 12;
    endtask

    // one cycle budget for all rows
    always @(posedge clk) begin
        if (dut_rst_n) begin
            cycles = cycles + 1;
            if (cycles > max_cycles) begin
                $display("timeout after %0d cycles, core never halted", cycles);
                $display("Test failed");
                $finish;
            end
        end
    end

    task automatic load_row(input int r);
        @(posedge clk);
        #1 run_rst_n = 1'b0;
        load_en = 1'b1;
        for (int a = 0; a < 256; a++) begin
            load_addr  = a[7:0];
            load_instr = (a < 12) ? rows[r].prog[a] :
                         {4'hf, a[5:0] ^ {4'b0, a[7:6]}, 6'd29};
            load_data  = rows[r].rand_fill ? word_t'($urandom) : {a[7:0], ~a[7:0]};
            @(posedge clk);
            #1;
        end
        load_en = 1'b0;
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        #1 run_rst_n = 1'b1;
    endtask

    task automatic sample_cycle();
        @(negedge clk);
        if (!is_halted && !read_m1) begin
            $display("read_m1 low while the core runs at %0t", $time);
            errors++;
        end
        if (output_valid)
            got.push_back(output_port);
    endtask

    task automatic watch_after_halt(input int exp_count);
        repeat (8) begin
            @(negedge clk);
            if (output_valid) begin
                $display("output_valid pulsed after halt at %0t", $time);
                errors++;
            end
            if (!is_halted) begin
                $display("is_halted dropped after halt at %0t", $time);
                errors++;
            end
            if (read_m1) begin
                $display("read_m1 still high after halt at %0t", $time);
                errors++;
            end
        end
        if (num_inst != word_t'(exp_count)) begin
            $display("Error at %0t: num_inst expected %0d got %0d", $time, exp_count, num_inst);
            errors++;
        end
    endtask

    task automatic run_row(input int r);
        int    start_err;
        word_t exp_q [$];
        start_err = errors;
        load_row(r);
        for (int i = 0; i < rows[r].n_exp; i++) begin
            if (rows[r].exp_addr[i] == 16'hffff)
                exp_q.push_back(rows[r].exp_val[i]);
            else
                exp_q.push_back(i_mem.dmem[rows[r].exp_addr[i][7:0]]);
        end
        got.delete();
        release_reset();
        if (rows[r].reset_after > 0) begin
            repeat (rows[r].reset_after) sample_cycle();
            if (num_inst == 16'd0) begin
                $display("row %0d made no progress before the mid reset", r);
                errors++;
            end
            @(posedge clk);
            #1 run_rst_n = 1'b0;
            @(negedge clk);
            if (num_inst != 16'd0) begin
                $display("Error at %0t: num_inst expected 0 got %0d", $time, num_inst);
                errors++;
            end
            got.delete();
            release_reset();
        end
        do sample_cycle(); while (!is_halted);
        watch_after_halt(rows[r].exp_count);
        if (got.size() != exp_q.size()) begin
            $display("row %0d expected %0d output values, saw %0d", r, exp_q.size(), got.size());
            errors++;
        end
        for (int i = 0; i < got.size() && i < exp_q.size(); i++) begin
            if (got[i] !== exp_q[i]) begin
                $display("Error at %0t: output_port[%0d] expected %h got %h",
                         $time, i, exp_q[i], got[i]);
                errors++;
            end
        end
        if (errors == start_err)
            passed++;
        $display("row %0d %s: %s", r, rows[r].name, (errors == start_err) ? "ok" : "mismatch");
    endtask

    initial begin
        errors     = 0;
        passed     = 0;
        cycles     = 0;
        run_rst_n  = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_instr = '0;
        load_data  = '0;
        void'($urandom(32'h18eb));
        build_table();
        wait (gen_rst_n);
        for (int r = 0; r < n_rows; r++)
            run_row(r);
        $display("%0d rows, %0d ok, %0d errors", n_rows, passed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tb.f
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_core.sv
verification/tb_clock_gen.sv
verification/tb_memory.sv
verification/cpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb \
    -f tb.f --Mdir obj_dir -o Vcpu_tb \
    && ./obj_dir/Vcpu_tb > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null

grep -q "^Test completed successfully$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation did not pass, see sim.log"; exit 1; }
